// ==== hdl/cpu_types_pkg.sv ====
package cpu_types_pkg;

  // Register file size and word width
  localparam int REG_COUNT = 32;
  localparam int WORD_W = 32;

  // Register index, zero is never a hazard source
  typedef logic [$clog2(REG_COUNT)-1:0] regbits_t;

  // Data word
  typedef logic [WORD_W-1:0] word_t;

  // Per-latch control from the hazard unit
  typedef enum logic [1:0] {
    PIPE_ENABLE = 2'b00,
    PIPE_STALL  = 2'b01,
    PIPE_NOP    = 2'b10
  } pipe_state_t;

  // PC source as decoded
  typedef logic [1:0] pcsrc_t;
  localparam pcsrc_t PC_SEQ    = 2'd0;
  localparam pcsrc_t PC_BRANCH = 2'd1;
  localparam pcsrc_t PC_JUMP   = 2'd2;
  localparam pcsrc_t PC_JR     = 2'd3;

  // ALU operand forward select
  typedef logic [1:0] fsel_t;
  localparam fsel_t FSEL_RF  = 2'd0;
  localparam fsel_t FSEL_WB  = 2'd1;
  localparam fsel_t FSEL_MEM = 2'd2;

endpackage

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
  input  pipe_fields_pkg::ex_fields_t  ex,
  input  cpu_types_pkg::fsel_t         fsel_a,
  input  cpu_types_pkg::fsel_t         fsel_b,
  input  cpu_types_pkg::word_t         mem_value,
  input  cpu_types_pkg::word_t         wb_value,
  output pipe_fields_pkg::mem_fields_t mem_next,
  output logic                         alu_zero
);

  cpu_types_pkg::word_t op_a;
  cpu_types_pkg::word_t op_b;
  cpu_types_pkg::word_t alu_result;

  // Operand source by forward select
  function automatic cpu_types_pkg::word_t fwd_mux(
    input cpu_types_pkg::fsel_t sel,
    input cpu_types_pkg::word_t rf_value,
    input cpu_types_pkg::word_t mem_v,
    input cpu_types_pkg::word_t wb_v
  );
    cpu_types_pkg::word_t result;
    case (sel)
      cpu_types_pkg::FSEL_MEM: result = mem_v;
      cpu_types_pkg::FSEL_WB:  result = wb_v;
      default:                 result = rf_value;
    endcase
    return result;
  endfunction

  assign op_a = fwd_mux(fsel_a, ex.rdat1, mem_value, wb_value);
  assign op_b = fwd_mux(fsel_b, ex.rdat2, mem_value, wb_value);

  // ALU
  always_comb begin
    case (ex.aluop)
      pipe_fields_pkg::ALU_ADD: alu_result = op_a + op_b;
      // Also the branch compare
      pipe_fields_pkg::ALU_SUB: alu_result = op_a - op_b;
      pipe_fields_pkg::ALU_OR:  alu_result = op_a | op_b;
      default:                  alu_result = op_b;
    endcase
  end

  assign alu_zero = (alu_result == '0);

  // Next memory payload
  always_comb begin
    mem_next = '0;
    // Bubble in gives bubble out
    if (ex.valid) begin
      mem_next.valid      = 1'b1;
      mem_next.rs         = ex.rs;
      mem_next.rt         = ex.rt;
      mem_next.wsel       = ex.wsel;
      mem_next.mem_read   = ex.mem_read;
      mem_next.mem_write  = ex.mem_write;
      mem_next.alu_result = alu_result;
      // Store data follows the forwarded B operand
      mem_next.store_data = op_b;
    end
  end

endmodule

// ==== hdl/hazard_pipe_top.sv ====
`timescale 1ns/1ps

module hazard_pipe_top (
  input  logic                       clk,
  input  logic                       reset,
  // Decoded instruction
  input  logic                       dec_valid,
  input  cpu_types_pkg::regbits_t    dec_rs,
  input  cpu_types_pkg::regbits_t    dec_rt,
  input  cpu_types_pkg::regbits_t    dec_wsel,
  input  pipe_fields_pkg::aluop_t    dec_aluop,
  input  logic                       dec_mem_read,
  input  logic                       dec_mem_write,
  input  cpu_types_pkg::pcsrc_t      dec_pcsrc,
  input  logic                       dec_check_zero,
  input  cpu_types_pkg::word_t       dec_rdat1,
  input  cpu_types_pkg::word_t       dec_rdat2,
  // Cache status and load data
  input  logic                       ihit,
  input  logic                       dhit,
  input  cpu_types_pkg::word_t       dload,
  // Fetch control
  output logic                       pc_wen,
  output cpu_types_pkg::pcsrc_t      pcsrc_check,
  output logic                       branching,
  output logic                       jumping,
  output cpu_types_pkg::pipe_state_t fd_state,
  // Data memory
  output logic                       dmem_ren,
  output logic                       dmem_wen,
  output cpu_types_pkg::word_t       dmem_addr,
  output cpu_types_pkg::word_t       dmem_store,
  // Register writeback
  output logic                       wb_wen,
  output cpu_types_pkg::regbits_t    wb_wsel,
  output cpu_types_pkg::word_t       wb_data
);

  pipe_fields_pkg::ex_fields_t  de_next;
  pipe_fields_pkg::ex_fields_t  de_q;
  pipe_fields_pkg::mem_fields_t em_next;
  pipe_fields_pkg::mem_fields_t em_q;
  pipe_fields_pkg::wb_fields_t  mw_next;
  pipe_fields_pkg::wb_fields_t  mw_q;

  cpu_types_pkg::pipe_state_t de_state;
  cpu_types_pkg::pipe_state_t em_state;
  cpu_types_pkg::pipe_state_t mw_state;
  cpu_types_pkg::fsel_t       fsel_a;
  cpu_types_pkg::fsel_t       fsel_b;
  logic                       fsel_sw;
  logic                       alu_zero;
  cpu_types_pkg::word_t       mem_value;

  // Pack decode fields
  always_comb begin
    de_next.valid      = dec_valid;
    de_next.rs         = dec_rs;
    de_next.rt         = dec_rt;
    de_next.wsel       = dec_wsel;
    de_next.aluop      = dec_aluop;
    de_next.mem_read   = dec_mem_read;
    de_next.mem_write  = dec_mem_write;
    de_next.pcsrc      = dec_pcsrc;
    de_next.check_zero = dec_check_zero;
    de_next.rdat1      = dec_rdat1;
    de_next.rdat2      = dec_rdat2;
  end

  pipe_latch #(.payload_t(pipe_fields_pkg::ex_fields_t)) u_de_latch (
    .clk   (clk),
    .reset (reset),
    .state (de_state),
    .d     (de_next),
    .q     (de_q)
  );

  execute_stage u_execute (
    .ex        (de_q),
    .fsel_a    (fsel_a),
    .fsel_b    (fsel_b),
    .mem_value (mem_value),
    .wb_value  (mw_q.wb_data),
    .mem_next  (em_next),
    .alu_zero  (alu_zero)
  );

  pipe_latch #(.payload_t(pipe_fields_pkg::mem_fields_t)) u_em_latch (
    .clk   (clk),
    .reset (reset),
    .state (em_state),
    .d     (em_next),
    .q     (em_q)
  );

  // Memory-stage result, load data for loads
  assign mem_value = em_q.mem_read ? dload : em_q.alu_result;

  assign dmem_ren   = em_q.mem_read;
  assign dmem_wen   = em_q.mem_write;
  assign dmem_addr  = em_q.alu_result;
  // Late store data from writeback
  assign dmem_store = fsel_sw ? mw_q.wb_data : em_q.store_data;

  assign mw_next.valid   = em_q.valid;
  assign mw_next.wsel    = em_q.wsel;
  assign mw_next.wb_data = mem_value;

  pipe_latch #(.payload_t(pipe_fields_pkg::wb_fields_t)) u_mw_latch (
    .clk   (clk),
    .reset (reset),
    .state (mw_state),
    .d     (mw_next),
    .q     (mw_q)
  );

  // Register zero is never written
  assign wb_wen  = mw_q.valid && (mw_q.wsel != '0);
  assign wb_wsel = mw_q.wsel;
  assign wb_data = mw_q.wb_data;

  hazard_unit u_hazard (
    .ihit          (ihit),
    .dhit          (dhit),
    .alu_zero      (alu_zero),
    .ex_rs         (de_q.rs),
    .ex_rt         (de_q.rt),
    .ex_pcsrc      (de_q.pcsrc),
    .ex_check_zero (de_q.check_zero),
    .mem_rt        (em_q.rt),
    .mem_wsel      (em_q.wsel),
    .wb_wsel       (mw_q.wsel),
    .mem_read      (em_q.mem_read),
    .mem_write     (em_q.mem_write),
    .pc_wen        (pc_wen),
    .branching     (branching),
    .jumping       (jumping),
    .pcsrc_check   (pcsrc_check),
    .de_state      (de_state),
    .em_state      (em_state),
    .mw_state      (mw_state),
    .fsel_a        (fsel_a),
    .fsel_b        (fsel_b),
    .fsel_sw       (fsel_sw)
  );

  // Fetch-decode follows the decode-execute rule
  assign fd_state = de_state;

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
  input  logic                       ihit,
  input  logic                       dhit,
  input  logic                       alu_zero,
  input  cpu_types_pkg::regbits_t    ex_rs,
  input  cpu_types_pkg::regbits_t    ex_rt,
  input  cpu_types_pkg::pcsrc_t      ex_pcsrc,
  input  logic                       ex_check_zero,
  input  cpu_types_pkg::regbits_t    mem_rt,
  input  cpu_types_pkg::regbits_t    mem_wsel,
  input  cpu_types_pkg::regbits_t    wb_wsel,
  input  logic                       mem_read,
  input  logic                       mem_write,
  output logic                       pc_wen,
  output logic                       branching,
  output logic                       jumping,
  output cpu_types_pkg::pcsrc_t      pcsrc_check,
  output cpu_types_pkg::pipe_state_t de_state,
  output cpu_types_pkg::pipe_state_t em_state,
  output cpu_types_pkg::pipe_state_t mw_state,
  output cpu_types_pkg::fsel_t       fsel_a,
  output cpu_types_pkg::fsel_t       fsel_b,
  output logic                       fsel_sw
);

  logic is_branch;
  logic taken;
  logic redirect;
  logic mem_load_done;
  logic mem_writes_reg;
  logic haz_rs_mem;
  logic haz_rt_mem;
  logic haz_rs_wb;
  logic haz_rt_wb;
  logic haz_rt_sw;

  // Advance the PC on an instruction hit unless data is still in flight
  assign pc_wen = (ihit && !dhit) || jumping;

  // Branch resolves in execute from the ALU zero flag
  assign is_branch = (ex_pcsrc == cpu_types_pkg::PC_BRANCH);
  // beq taken on zero, bne taken on nonzero
  assign taken = (ex_check_zero == alu_zero);
  assign branching = is_branch && taken;

  assign jumping = (ex_pcsrc == cpu_types_pkg::PC_JUMP) ||
                   (ex_pcsrc == cpu_types_pkg::PC_JR);

  // Untaken branch falls back to sequential
  always_comb begin
    if (is_branch && !taken) begin
      pcsrc_check = cpu_types_pkg::PC_SEQ;
    end else begin
      pcsrc_check = ex_pcsrc;
    end
  end

  assign redirect = branching || jumping;
  // Load in memory stage whose data has returned
  assign mem_load_done = dhit && mem_read;

  // Decode-execute latch
  always_comb begin
    de_state = cpu_types_pkg::PIPE_STALL;
    if (redirect) begin
      // Squash the wrong-path instruction
      de_state = cpu_types_pkg::PIPE_NOP;
    end else if (ihit) begin
      de_state = cpu_types_pkg::PIPE_ENABLE;
    end
  end

  // Execute-memory latch
  always_comb begin
    em_state = cpu_types_pkg::PIPE_STALL;
    if (redirect) begin
      em_state = cpu_types_pkg::PIPE_NOP;
    end else if (ihit) begin
      em_state = cpu_types_pkg::PIPE_ENABLE;
    end else if (mem_load_done) begin
      em_state = cpu_types_pkg::PIPE_ENABLE;
    end
  end

  // Memory-writeback latch, never squashed
  always_comb begin
    mw_state = cpu_types_pkg::PIPE_STALL;
    if (ihit) begin
      mw_state = cpu_types_pkg::PIPE_ENABLE;
    end else if (mem_load_done) begin
      mw_state = cpu_types_pkg::PIPE_ENABLE;
    end
  end

  // Stores write no register, bubbles carry wsel zero
  assign mem_writes_reg = !mem_write && (mem_wsel != '0);

  // Execute operands against memory and writeback destinations
  assign haz_rs_mem = mem_writes_reg && (ex_rs != '0) && (ex_rs == mem_wsel);
  assign haz_rt_mem = mem_writes_reg && (ex_rt != '0) && (ex_rt == mem_wsel);
  assign haz_rs_wb  = (ex_rs != '0) && (ex_rs == wb_wsel);
  assign haz_rt_wb  = (ex_rt != '0) && (ex_rt == wb_wsel);
  // Store data in memory stage against writeback
  assign haz_rt_sw  = (mem_rt != '0) && (mem_rt == wb_wsel);

  // Port A, youngest producer wins
  always_comb begin
    if (haz_rs_mem) begin
      fsel_a = cpu_types_pkg::FSEL_MEM;
    end else if (haz_rs_wb) begin
      fsel_a = cpu_types_pkg::FSEL_WB;
    end else begin
      fsel_a = cpu_types_pkg::FSEL_RF;
    end
  end

  // Port B, same priority
  always_comb begin
    if (haz_rt_mem) begin
      fsel_b = cpu_types_pkg::FSEL_MEM;
    end else if (haz_rt_wb) begin
      fsel_b = cpu_types_pkg::FSEL_WB;
    end else begin
      fsel_b = cpu_types_pkg::FSEL_RF;
    end
  end

  assign fsel_sw = haz_rt_sw;

  // Branch and jump redirects are exclusive
  always_comb begin
    a_one_redirect: assert (!(branching && jumping))
      else $error("hazard_unit: branching and jumping together");
  end

endmodule

// ==== hdl/pipe_fields_pkg.sv ====
package pipe_fields_pkg;

  // ALU operations, add is zero so a bubble decodes as add
  typedef enum logic [1:0] {
    ALU_ADD   = 2'd0,
    ALU_SUB   = 2'd1,
    ALU_OR    = 2'd2,
    ALU_PASSB = 2'd3
  } aluop_t;

  // Decode-execute payload
  typedef struct packed {
    logic                   valid;
    cpu_types_pkg::regbits_t rs;
    cpu_types_pkg::regbits_t rt;
    cpu_types_pkg::regbits_t wsel;
    aluop_t                 aluop;
    logic                   mem_read;
    logic                   mem_write;
    cpu_types_pkg::pcsrc_t  pcsrc;
    // High for beq, low for bne
    logic                   check_zero;
    cpu_types_pkg::word_t   rdat1;
    cpu_types_pkg::word_t   rdat2;
  } ex_fields_t;

  // Execute-memory payload
  typedef struct packed {
    logic                   valid;
    cpu_types_pkg::regbits_t rs;
    cpu_types_pkg::regbits_t rt;
    cpu_types_pkg::regbits_t wsel;
    logic                   mem_read;
    logic                   mem_write;
    cpu_types_pkg::word_t   alu_result;
    cpu_types_pkg::word_t   store_data;
  } mem_fields_t;

  // Memory-writeback payload
  typedef struct packed {
    logic                   valid;
    cpu_types_pkg::regbits_t wsel;
    cpu_types_pkg::word_t   wb_data;
  } wb_fields_t;

endpackage

// ==== hdl/pipe_latch.sv ====
`timescale 1ns/1ps

module pipe_latch #(
  parameter type payload_t = logic
) (
  input  logic                       clk,
  input  logic                       reset,
  input  cpu_types_pkg::pipe_state_t state,
  input  payload_t                   d,
  output payload_t                   q
);

  // All-zero payload is a bubble
  localparam payload_t BUBBLE = payload_t'('0);

  always_ff @(posedge clk) begin
    if (reset) begin
      // Pipeline comes up empty
      q <= BUBBLE;
    end else begin
      case (state)
        cpu_types_pkg::PIPE_ENABLE: begin
          q <= d;
        end
        cpu_types_pkg::PIPE_NOP: begin
          // Squash the stage
          q <= BUBBLE;
        end
        default: begin
          // Stall holds the stage
          q <= q;
        end
      endcase
    end
  end

  // Hazard unit never drives the spare encoding
  a_state_legal: assert property (
    @(posedge clk) disable iff (reset)
    2'(state) != 2'b11
  ) else $error("pipe_latch: illegal state encoding");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the hazard pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module hazard_pipe_tb -Mdir obj_dir -f verilog.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vhazard_pipe_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only when the testbench reported success
if printf '%s\n' "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// ==== verif/hazard_pipe_tb.sv ====
`timescale 1ns/1ps

module hazard_pipe_tb;

  // Roughly 70 cycles of tests plus reset, with generous margin
  localparam int MAX_CYCLES = 400;
  // Register file data that forwarding must override
  localparam cpu_types_pkg::word_t STALE = 32'hdead_beef;

  typedef struct packed {
    logic                    wen;
    cpu_types_pkg::regbits_t wsel;
    cpu_types_pkg::word_t    data;
  } wb_expect_t;

  logic                       clk;
  logic                       reset;
  logic                       dec_valid;
  cpu_types_pkg::regbits_t    dec_rs;
  cpu_types_pkg::regbits_t    dec_rt;
  cpu_types_pkg::regbits_t    dec_wsel;
  pipe_fields_pkg::aluop_t    dec_aluop;
  logic                       dec_mem_read;
  logic                       dec_mem_write;
  cpu_types_pkg::pcsrc_t      dec_pcsrc;
  logic                       dec_check_zero;
  cpu_types_pkg::word_t       dec_rdat1;
  cpu_types_pkg::word_t       dec_rdat2;
  logic                       ihit;
  logic                       dhit;
  cpu_types_pkg::word_t       dload;
  logic                       pc_wen;
  cpu_types_pkg::pcsrc_t      pcsrc_check;
  logic                       branching;
  logic                       jumping;
  cpu_types_pkg::pipe_state_t fd_state;
  logic                       dmem_ren;
  logic                       dmem_wen;
  cpu_types_pkg::word_t       dmem_addr;
  cpu_types_pkg::word_t       dmem_store;
  logic                       wb_wen;
  cpu_types_pkg::regbits_t    wb_wsel;
  cpu_types_pkg::word_t       wb_data;

  // Expected writeback, one entry per issued slot
  wb_expect_t exp_q[$];
  integer     seed = 32'hddd8bbac;
  int         errors = 0;
  int         checks = 0;
  int         cycle_count = 0;

  hazard_pipe_top u_hazard_pipe_top (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit
  initial begin
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: simulation ran past %0d cycles without finishing", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_word(input string what, input cpu_types_pkg::word_t got,
                            input cpu_types_pkg::word_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("mismatch at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic check_reg(input string what, input cpu_types_pkg::regbits_t got,
                           input cpu_types_pkg::regbits_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("mismatch at %0t: %s is r%0d, expected r%0d", $time, what, got, expected);
    end
  endtask

  task automatic check_state(input string what, input cpu_types_pkg::pipe_state_t got,
                             input cpu_types_pkg::pipe_state_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("mismatch at %0t: %s is %s, expected %s", $time, what, got.name(),
               expected.name());
    end
  endtask

  task automatic check_pcsrc(input string what, input cpu_types_pkg::pcsrc_t got,
                             input cpu_types_pkg::pcsrc_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, expected);
    end
  endtask

  // Empty decode slot, all fields zero
  task automatic clear_decode();
    dec_valid      = 1'b0;
    dec_rs         = '0;
    dec_rt         = '0;
    dec_wsel       = '0;
    dec_aluop      = pipe_fields_pkg::ALU_ADD;
    dec_mem_read   = 1'b0;
    dec_mem_write  = 1'b0;
    dec_pcsrc      = cpu_types_pkg::PC_SEQ;
    dec_check_zero = 1'b0;
    dec_rdat1      = '0;
    dec_rdat2      = '0;
  endtask

  // Sequential ALU instruction, 2 ns after the next rising edge
  task automatic issue_alu(input cpu_types_pkg::regbits_t rs, input cpu_types_pkg::regbits_t rt,
                           input cpu_types_pkg::regbits_t wsel,
                           input pipe_fields_pkg::aluop_t op,
                           input cpu_types_pkg::word_t rdat1, input cpu_types_pkg::word_t rdat2);
    @(posedge clk);
    #2;
    clear_decode();
    dec_valid = 1'b1;
    dec_rs    = rs;
    dec_rt    = rt;
    dec_wsel  = wsel;
    dec_aluop = op;
    dec_rdat1 = rdat1;
    dec_rdat2 = rdat2;
  endtask

  task automatic issue_bubble();
    @(posedge clk);
    #2;
    clear_decode();
  endtask

  // Queue this slot, then check the slot issued three edges earlier
  task automatic expect_slot(input logic wen, input cpu_types_pkg::regbits_t wsel,
                             input cpu_types_pkg::word_t data);
    wb_expect_t slot;
    wb_expect_t oldest;
    slot.wen  = wen;
    slot.wsel = wsel;
    slot.data = data;
    exp_q.push_back(slot);
    #1;
    if (exp_q.size() > 3) begin
      oldest = exp_q.pop_front();
      check_bit("wb_wen", wb_wen, oldest.wen);
      if (oldest.wen) begin
        check_reg("wb_wsel", wb_wsel, oldest.wsel);
        check_word("wb_data", wb_data, oldest.data);
      end
    end
  endtask

  // Bubbles until every queued slot has been checked
  task automatic drain();
    repeat (3) begin
      issue_bubble();
      expect_slot(1'b0, '0, '0);
    end
    exp_q.delete();
  endtask

  task automatic test_reset_latency();
    cpu_types_pkg::word_t r [0:1];
    foreach (r[i]) r[i] = $random(seed);
    #1;
    // Empty pipeline, nothing fetched yet
    check_bit("wb_wen after reset", wb_wen, 1'b0);
    check_bit("dmem_ren after reset", dmem_ren, 1'b0);
    check_bit("dmem_wen after reset", dmem_wen, 1'b0);
    check_state("fd_state after reset", fd_state, cpu_types_pkg::PIPE_STALL);
    issue_alu(5'd1, 5'd2, 5'd3, pipe_fields_pkg::ALU_ADD, r[0], r[1]);
    ihit = 1'b1;
    expect_slot(1'b1, 5'd3, r[0] + r[1]);
    // Not yet at writeback after one and two edges
    issue_bubble();
    expect_slot(1'b0, '0, '0);
    check_bit("wb_wen one edge in", wb_wen, 1'b0);
    issue_bubble();
    expect_slot(1'b0, '0, '0);
    check_bit("wb_wen two edges in", wb_wen, 1'b0);
    issue_bubble();
    expect_slot(1'b0, '0, '0);
    drain();
  endtask

  task automatic test_forwarding();
    cpu_types_pkg::word_t r [0:11];
    foreach (r[i]) r[i] = $random(seed);
    // Back to back, rs from the memory stage
    issue_alu(5'd1, 5'd2, 5'd5, pipe_fields_pkg::ALU_ADD, r[0], r[1]);
    expect_slot(1'b1, 5'd5, r[0] + r[1]);
    issue_alu(5'd5, 5'd7, 5'd6, pipe_fields_pkg::ALU_SUB, STALE, r[2]);
    expect_slot(1'b1, 5'd6, (r[0] + r[1]) - r[2]);
    // Gap of one, rt from writeback
    issue_alu(5'd10, 5'd11, 5'd8, pipe_fields_pkg::ALU_OR, r[3], r[4]);
    expect_slot(1'b1, 5'd8, r[3] | r[4]);
    issue_bubble();
    expect_slot(1'b0, '0, '0);
    issue_alu(5'd12, 5'd8, 5'd9, pipe_fields_pkg::ALU_ADD, r[5], STALE);
    expect_slot(1'b1, 5'd9, r[5] + (r[3] | r[4]));
    // r11 written twice, younger value must win
    issue_alu(5'd13, 5'd14, 5'd11, pipe_fields_pkg::ALU_PASSB, STALE, r[6]);
    expect_slot(1'b1, 5'd11, r[6]);
    issue_alu(5'd15, 5'd16, 5'd11, pipe_fields_pkg::ALU_PASSB, STALE, r[7]);
    expect_slot(1'b1, 5'd11, r[7]);
    issue_alu(5'd11, 5'd18, 5'd17, pipe_fields_pkg::ALU_ADD, STALE, r[8]);
    expect_slot(1'b1, 5'd17, r[7] + r[8]);
    // Write to r0 is dropped and not forwarded
    issue_alu(5'd19, 5'd20, 5'd0, pipe_fields_pkg::ALU_ADD, r[9], r[10]);
    expect_slot(1'b0, '0, '0);
    issue_alu(5'd0, 5'd22, 5'd21, pipe_fields_pkg::ALU_ADD, '0, r[11]);
    expect_slot(1'b1, 5'd21, r[11]);
    drain();
  endtask

  task automatic test_store_forward();
    cpu_types_pkg::word_t r [0:2];
    foreach (r[i]) r[i] = $random(seed);
    r[0] = r[0] & 32'h0000_fffc;
    issue_alu(5'd23, 5'd0, 5'd4, pipe_fields_pkg::ALU_ADD, r[0], '0);
    dec_mem_read = 1'b1;
    dload = r[1];
    expect_slot(1'b1, 5'd4, r[1]);
    // Store of the loaded register
    issue_alu(5'd24, 5'd4, 5'd0, pipe_fields_pkg::ALU_ADD, r[2], STALE);
    dec_mem_write = 1'b1;
    expect_slot(1'b0, '0, '0);
    issue_bubble();
    expect_slot(1'b0, '0, '0);
    check_bit("dmem_ren for load", dmem_ren, 1'b1);
    check_word("dmem_addr for load", dmem_addr, r[0]);
    issue_bubble();
    expect_slot(1'b0, '0, '0);
    check_bit("dmem_wen for store", dmem_wen, 1'b1);
    check_word("dmem_store", dmem_store, r[1]);
    check_word("dmem_addr for store", dmem_addr, r[2] + r[1]);
    drain();
  endtask

  task automatic test_branch_jump();
    cpu_types_pkg::word_t v;
    v = $random(seed);
    // Taken beq squashes the next slot
    issue_alu(5'd25, 5'd26, 5'd0, pipe_fields_pkg::ALU_SUB, v, v);
    dec_pcsrc      = cpu_types_pkg::PC_BRANCH;
    dec_check_zero = 1'b1;
    expect_slot(1'b0, '0, '0);
    issue_alu(5'd28, 5'd29, 5'd27, pipe_fields_pkg::ALU_ADD, v, 32'd1);
    expect_slot(1'b0, '0, '0);
    check_bit("branching on taken beq", branching, 1'b1);
    check_bit("jumping on taken beq", jumping, 1'b0);
    check_pcsrc("pcsrc_check on taken beq", pcsrc_check, cpu_types_pkg::PC_BRANCH);
    check_state("fd_state on taken beq", fd_state, cpu_types_pkg::PIPE_NOP);
    check_bit("pc_wen on taken beq", pc_wen, 1'b1);
    // Untaken beq lets the next slot through
    issue_alu(5'd25, 5'd26, 5'd0, pipe_fields_pkg::ALU_SUB, v, v + 32'd1);
    dec_pcsrc      = cpu_types_pkg::PC_BRANCH;
    dec_check_zero = 1'b1;
    expect_slot(1'b0, '0, '0);
    issue_alu(5'd28, 5'd29, 5'd27, pipe_fields_pkg::ALU_ADD, v, 32'd1);
    expect_slot(1'b1, 5'd27, v + 32'd1);
    check_bit("branching on untaken beq", branching, 1'b0);
    check_pcsrc("pcsrc_check on untaken beq", pcsrc_check, cpu_types_pkg::PC_SEQ);
    check_state("fd_state on untaken beq", fd_state, cpu_types_pkg::PIPE_ENABLE);
    // Jump with dhit high, so only the jump can raise pc_wen
    issue_alu(5'd0, 5'd0, 5'd0, pipe_fields_pkg::ALU_ADD, '0, '0);
    dec_pcsrc = cpu_types_pkg::PC_JUMP;
    expect_slot(1'b0, '0, '0);
    issue_alu(5'd28, 5'd29, 5'd30, pipe_fields_pkg::ALU_ADD, v, 32'd2);
    dhit = 1'b1;
    expect_slot(1'b0, '0, '0);
    check_bit("jumping on jump", jumping, 1'b1);
    check_bit("branching on jump", branching, 1'b0);
    check_bit("pc_wen on jump", pc_wen, 1'b1);
    check_pcsrc("pcsrc_check on jump", pcsrc_check, cpu_types_pkg::PC_JUMP);
    check_state("fd_state on jump", fd_state, cpu_types_pkg::PIPE_NOP);
    issue_bubble();
    dhit = 1'b0;
    expect_slot(1'b0, '0, '0);
    drain();
  endtask

  task automatic test_stalls();
    cpu_types_pkg::word_t r [0:3];
    foreach (r[i]) r[i] = $random(seed);
    // ADD into the memory stage, then both caches miss
    issue_alu(5'd1, 5'd2, 5'd24, pipe_fields_pkg::ALU_ADD, r[0], r[1]);
    issue_bubble();
    issue_bubble();
    ihit = 1'b0;
    #1;
    check_bit("pc_wen on miss", pc_wen, 1'b0);
    check_state("fd_state on miss", fd_state, cpu_types_pkg::PIPE_STALL);
    repeat (3) begin
      issue_bubble();
      #1;
      check_bit("pc_wen while held", pc_wen, 1'b0);
      check_word("dmem_addr while held", dmem_addr, r[0] + r[1]);
      check_bit("wb_wen while held", wb_wen, 1'b0);
    end
    issue_bubble();
    ihit = 1'b1;
    issue_bubble();
    #1;
    check_bit("wb_wen after release", wb_wen, 1'b1);
    check_reg("wb_wsel after release", wb_wsel, 5'd24);
    check_word("wb_data after release", wb_data, r[0] + r[1]);
    // Load completes on dhit while fetch misses
    issue_alu(5'd26, 5'd0, 5'd9, pipe_fields_pkg::ALU_ADD, r[2], '0);
    dec_mem_read = 1'b1;
    dload = r[3];
    issue_bubble();
    issue_bubble();
    ihit = 1'b0;
    dhit = 1'b1;
    #1;
    check_bit("dmem_ren for stalled load", dmem_ren, 1'b1);
    check_state("fd_state on dhit", fd_state, cpu_types_pkg::PIPE_STALL);
    check_bit("pc_wen on dhit", pc_wen, 1'b0);
    issue_bubble();
    #1;
    check_bit("wb_wen for load", wb_wen, 1'b1);
    check_reg("wb_wsel for load", wb_wsel, 5'd9);
    check_word("wb_data for load", wb_data, r[3]);
    check_state("fd_state after load", fd_state, cpu_types_pkg::PIPE_STALL);
    issue_bubble();
    ihit = 1'b1;
    dhit = 1'b0;
    drain();
  endtask

  initial begin
    reset = 1'b1;
    ihit  = 1'b0;
    dhit  = 1'b0;
    dload = '0;
    clear_decode();
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset_latency();
    test_forwarding();
    test_store_forward();
    test_branch_jump();
    test_stalls();
    $display("checks: %0d, mismatches: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/cpu_types_pkg.sv
hdl/pipe_fields_pkg.sv
hdl/pipe_latch.sv
hdl/execute_stage.sv
hdl/hazard_unit.sv
hdl/hazard_pipe_top.sv
verif/hazard_pipe_tb.sv
